//--- source/kronos_settings.svh
// ==============================
// Kronos lite build settings
// ==============================

`ifndef KRONOS_SETTINGS_SVH
`define KRONOS_SETTINGS_SVH

// Program counter after reset
`define KRONOS_BOOT_ADDR 32'h0000_0000

// Integer register count, x0 included
`define KRONOS_NREGS 32

`endif

//--- source/kronos_types.sv
// ==============================
// Kronos lite shared types
// ==============================

package kronos_types;

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLT, PASS
  } alu_op_t;

  // ==============================
  // Instruction formats
  // ==============================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } instr_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_j_t;

  // One instruction word, six ways to read it
  typedef union packed {
    instr_r_t r_fmt;
    instr_i_t i_fmt;
    instr_s_t s_fmt;
    instr_b_t b_fmt;
    instr_u_t u_fmt;
    instr_j_t j_fmt;
  } instr_u;

  // ==============================
  // Stage registers
  // ==============================
  typedef struct packed {
    logic [31:0] pc;
    instr_u      instr;
  } pipe_if_id_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] store_data;
    logic [31:0] imm;
    logic [4:0]  rd;
    alu_op_t     alu_op;
    logic        wb_en;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jal;
  } pipe_id_ex_t;

endpackage

//--- source/kronos_fetch.sv
// ==============================
// Kronos lite fetch stage
// Instruction req/ack, one word in flight
// ==============================

`timescale 1ns/1ps

module kronos_fetch #(
  parameter logic [31:0] BOOT_ADDR = 32'h0
)(
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [31:0]               instr_addr,
  output logic                      instr_req,
  input  logic                      instr_ack,
  input  logic [31:0]               instr_data,
  output kronos_types::pipe_if_id_t fetch,
  output logic                      fetch_vld,
  input  logic                      fetch_rdy,
  input  logic                      branch,
  input  logic [31:0]               branch_target
);

  // Next address to request
  logic [31:0] pc;
  // Word of an aborted request is dropped
  logic        discard;
  logic        instr_done;
  logic        slot_free;

  assign instr_done = instr_req && instr_ack;
  assign slot_free  = !fetch_vld || fetch_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= BOOT_ADDR;
      instr_addr <= BOOT_ADDR;
      instr_req  <= 1'b0;
      discard    <= 1'b0;
      fetch_vld  <= 1'b0;
    end else if (branch) begin
      pc        <= branch_target;
      fetch_vld <= 1'b0;
      // Request in flight still waits for its ack
      if (instr_done) begin
        instr_req <= 1'b0;
        discard   <= 1'b0;
      end else if (instr_req) begin
        discard <= 1'b1;
      end
    end else begin
      if (fetch_vld && fetch_rdy) begin
        fetch_vld <= 1'b0;
      end
      if (instr_done) begin
        instr_req <= 1'b0;
        discard   <= 1'b0;
        if (!discard) begin
          fetch_vld <= 1'b1;
          pc        <= instr_addr + 32'd4;
        end
      end else if (!instr_req && slot_free) begin
        instr_req  <= 1'b1;
        instr_addr <= pc;
      end
    end
  end

  // Output word, captured on ack
  always_ff @(posedge clk) begin
    if (!branch && instr_done && !discard) begin
      fetch.pc    <= instr_addr;
      fetch.instr <= instr_data;
    end
  end

endmodule

//--- source/kronos_regfile.sv
// ==============================
// Kronos lite register file
// ==============================

`timescale 1ns/1ps
`include "kronos_settings.svh"

module kronos_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1_sel,
  input  logic [4:0]  rs2_sel,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wr_en,
  input  logic [4:0]  wr_sel,
  input  logic [31:0] wr_data
);

  // x0 is not stored
  logic [31:0] regs [1:`KRONOS_NREGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `KRONOS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_sel != 5'd0) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Write-first read, new data visible in the write cycle
  always_comb begin
    rs1_data = (rs1_sel == 5'd0) ? 32'd0 :
               (wr_en && wr_sel == rs1_sel) ? wr_data : regs[rs1_sel];
    rs2_data = (rs2_sel == 5'd0) ? 32'd0 :
               (wr_en && wr_sel == rs2_sel) ? wr_data : regs[rs2_sel];
  end

endmodule

//--- source/kronos_decode.sv
// ==============================
// Kronos lite decode stage
// Operands, immediate and hazard hold
// ==============================

`timescale 1ns/1ps

module kronos_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  kronos_types::pipe_if_id_t fetch,
  input  logic                      fetch_vld,
  output logic                      fetch_rdy,
  output kronos_types::pipe_id_ex_t decode,
  output logic                      decode_vld,
  input  logic                      decode_rdy,
  input  logic                      regwr_en,
  input  logic [4:0]                regwr_sel,
  input  logic [31:0]               regwr_data
);

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  kronos_types::instr_u      instr;
  kronos_types::pipe_id_ex_t dec_next;
  kronos_types::alu_op_t     alu_sel;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        alu_ok;
  logic        use_rs1;
  logic        use_rs2;
  logic        ex_pend;
  logic [4:0]  ex_rd;
  logic        id_hit;
  logic        ex_hit;

  assign instr = fetch.instr;

  kronos_regfile u_regfile (
    .clk     (clk               ),
    .rst_n   (rst_n             ),
    .rs1_sel (instr.r_fmt.rs1   ),
    .rs2_sel (instr.r_fmt.rs2   ),
    .rs1_data(rs1_data          ),
    .rs2_data(rs2_data          ),
    .wr_en   (regwr_en          ),
    .wr_sel  (regwr_sel         ),
    .wr_data (regwr_data        )
  );

  // ALU select from funct3, SUB only for register ops
  always_comb begin
    alu_ok  = 1'b1;
    alu_sel = kronos_types::ADD;
    case (instr.r_fmt.funct3)
      3'b000: alu_sel = (instr.r_fmt.opcode == OPC_REG && instr.r_fmt.funct7[5]) ?
                        kronos_types::SUB : kronos_types::ADD;
      3'b010: alu_sel = kronos_types::SLT;
      3'b100: alu_sel = kronos_types::XOR;
      3'b110: alu_sel = kronos_types::OR;
      3'b111: alu_sel = kronos_types::AND;
      default: alu_ok = 1'b0;
    endcase
  end

  always_comb begin
    dec_next            = '0;
    dec_next.pc         = fetch.pc;
    dec_next.op1        = rs1_data;
    dec_next.op2        = rs2_data;
    dec_next.store_data = rs2_data;
    dec_next.rd         = instr.r_fmt.rd;
    dec_next.alu_op     = kronos_types::ADD;
    use_rs1             = 1'b0;
    use_rs2             = 1'b0;
    case (instr.r_fmt.opcode)
      OPC_REG: begin
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        dec_next.alu_op = alu_sel;
        dec_next.wb_en  = alu_ok;
      end
      OPC_IMM, OPC_LOAD: begin
        use_rs1          = 1'b1;
        dec_next.imm     = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
        dec_next.op2     = dec_next.imm;
        dec_next.alu_op  = alu_sel;
        dec_next.is_load = (instr.r_fmt.opcode == OPC_LOAD);
        dec_next.wb_en   = alu_ok || dec_next.is_load;
      end
      OPC_STORE: begin
        use_rs1           = 1'b1;
        use_rs2           = 1'b1;
        dec_next.imm      = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                             instr.s_fmt.imm_4_0};
        dec_next.is_store = 1'b1;
      end
      OPC_BRANCH: begin
        use_rs1            = 1'b1;
        use_rs2            = 1'b1;
        dec_next.imm       = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                              instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                              instr.b_fmt.imm_4_1, 1'b0};
        dec_next.is_branch = (instr.b_fmt.funct3[2:1] == 2'b00);
        dec_next.branch_ne = instr.b_fmt.funct3[0];
      end
      OPC_LUI: begin
        dec_next.imm    = {instr.u_fmt.imm_31_12, 12'h000};
        dec_next.op2    = dec_next.imm;
        dec_next.alu_op = kronos_types::PASS;
        dec_next.wb_en  = 1'b1;
      end
      OPC_JAL: begin
        // Link value is pc + 4
        dec_next.imm    = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                           instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                           instr.j_fmt.imm_10_1, 1'b0};
        dec_next.op1    = fetch.pc;
        dec_next.op2    = 32'd4;
        dec_next.is_jal = 1'b1;
        dec_next.wb_en  = 1'b1;
      end
      default: ;
    endcase
    dec_next.wb_en = dec_next.wb_en && (instr.r_fmt.rd != 5'd0);
  end

  // Sources still owed a write by decode or execute
  assign id_hit = decode_vld && decode.wb_en &&
                  ((use_rs1 && decode.rd == instr.r_fmt.rs1) ||
                   (use_rs2 && decode.rd == instr.r_fmt.rs2));
  assign ex_hit = ex_pend && !(regwr_en && regwr_sel == ex_rd) &&
                  ((use_rs1 && ex_rd == instr.r_fmt.rs1) ||
                   (use_rs2 && ex_rd == instr.r_fmt.rs2));

  assign fetch_rdy = !flush && (!decode_vld || decode_rdy) && !id_hit && !ex_hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      decode_vld <= 1'b0;
      ex_pend    <= 1'b0;
      ex_rd      <= 5'd0;
    end else begin
      if (flush) begin
        decode_vld <= 1'b0;
      end else if (fetch_vld && fetch_rdy) begin
        decode_vld <= 1'b1;
      end else if (decode_rdy) begin
        decode_vld <= 1'b0;
      end
      // Destination of the item held in execute
      if (decode_vld && decode_rdy) begin
        ex_pend <= decode.wb_en;
        ex_rd   <= decode.rd;
      end else if (regwr_en && regwr_sel == ex_rd) begin
        ex_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_vld && fetch_rdy) begin
      decode <= dec_next;
    end
  end

endmodule

//--- source/kronos_execute.sv
// ==============================
// Kronos lite execute stage
// ALU, branches, load/store, write back
// ==============================

`timescale 1ns/1ps

module kronos_execute (
  input  logic                      clk,
  input  logic                      rst_n,
  input  kronos_types::pipe_id_ex_t decode,
  input  logic                      decode_vld,
  output logic                      decode_rdy,
  output logic                      regwr_en,
  output logic [4:0]                regwr_sel,
  output logic [31:0]               regwr_data,
  output logic                      branch,
  output logic [31:0]               branch_target,
  output logic [31:0]               data_addr,
  output logic [31:0]               data_wr_data,
  output logic [3:0]                data_mask,
  output logic                      data_wr_en,
  output logic                      data_req,
  input  logic                      data_ack,
  input  logic [31:0]               data_rd_data
);

  kronos_types::pipe_id_ex_t ex;
  logic        ex_vld;
  logic        is_mem;
  logic        retire;
  logic        op_eq;
  logic [31:0] alu_out;

  // ==============================
  // Stage register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_vld <= 1'b0;
    end else if (decode_vld && decode_rdy) begin
      ex_vld <= 1'b1;
    end else if (retire) begin
      ex_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (decode_vld && decode_rdy) begin
      ex <= decode;
    end
  end

  // Memory ops wait for ack, the rest leave after one cycle
  assign is_mem = ex.is_load || ex.is_store;
  assign retire = ex_vld && (!is_mem || data_ack);

  // Nothing enters behind a taken branch
  assign decode_rdy = (!ex_vld || retire) && !branch;

  // ==============================
  // ALU and compare
  // ==============================
  always_comb begin
    case (ex.alu_op)
      kronos_types::ADD:  alu_out = ex.op1 + ex.op2;
      kronos_types::SUB:  alu_out = ex.op1 - ex.op2;
      kronos_types::AND:  alu_out = ex.op1 & ex.op2;
      kronos_types::OR:   alu_out = ex.op1 | ex.op2;
      kronos_types::XOR:  alu_out = ex.op1 ^ ex.op2;
      kronos_types::SLT:  alu_out = {31'd0, $signed(ex.op1) < $signed(ex.op2)};
      kronos_types::PASS: alu_out = ex.op2;
      default:            alu_out = 32'd0;
    endcase
  end

  assign op_eq = (ex.op1 == ex.op2);

  // Taken BEQ/BNE or JAL, a single cycle since both retire at once
  assign branch        = ex_vld && (ex.is_jal || (ex.is_branch && (op_eq != ex.branch_ne)));
  assign branch_target = ex.pc + ex.imm;

  // ==============================
  // Data port
  // ==============================
  assign data_addr    = ex.op1 + ex.imm;
  assign data_wr_data = ex.store_data;
  // Word accesses only
  assign data_mask    = 4'hF;
  assign data_req     = ex_vld && is_mem;
  assign data_wr_en   = ex_vld && ex.is_store;

  // Write back
  assign regwr_en   = retire && ex.wb_en;
  assign regwr_sel  = ex.rd;
  assign regwr_data = ex.is_load ? data_rd_data : alu_out;

endmodule

//--- source/kronos_core.sv
// ==============================
// Kronos lite core top
// Three stage RV32I subset pipeline
// ==============================

`timescale 1ns/1ps
`include "kronos_settings.svh"

module kronos_core #(
  parameter logic [31:0] BOOT_ADDR = `KRONOS_BOOT_ADDR
)(
  input  logic        clk,
  input  logic        rst_n,
  // Instruction port
  output logic [31:0] instr_addr,
  output logic        instr_req,
  input  logic        instr_ack,
  input  logic [31:0] instr_data,
  // Data port
  output logic [31:0] data_addr,
  output logic [31:0] data_wr_data,
  output logic [3:0]  data_mask,
  output logic        data_wr_en,
  output logic        data_req,
  input  logic        data_ack,
  input  logic [31:0] data_rd_data
);

  kronos_types::pipe_if_id_t fetch;
  kronos_types::pipe_id_ex_t decode;
  logic        fetch_vld;
  logic        fetch_rdy;
  logic        decode_vld;
  logic        decode_rdy;
  logic        branch;
  logic [31:0] branch_target;
  logic        flush;
  logic        regwr_en;
  logic [4:0]  regwr_sel;
  logic [31:0] regwr_data;

  // Taken branch clears fetch and decode
  assign flush = branch;

  // ==============================
  // Fetch
  // ==============================
  kronos_fetch #(
    .BOOT_ADDR(BOOT_ADDR)
  ) u_fetch (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .instr_addr   (instr_addr   ),
    .instr_req    (instr_req    ),
    .instr_ack    (instr_ack    ),
    .instr_data   (instr_data   ),
    .fetch        (fetch        ),
    .fetch_vld    (fetch_vld    ),
    .fetch_rdy    (fetch_rdy    ),
    .branch       (branch       ),
    .branch_target(branch_target)
  );

  // ==============================
  // Decode
  // ==============================
  kronos_decode u_decode (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .flush     (flush     ),
    .fetch     (fetch     ),
    .fetch_vld (fetch_vld ),
    .fetch_rdy (fetch_rdy ),
    .decode    (decode    ),
    .decode_vld(decode_vld),
    .decode_rdy(decode_rdy),
    .regwr_en  (regwr_en  ),
    .regwr_sel (regwr_sel ),
    .regwr_data(regwr_data)
  );

  // ==============================
  // Execute
  // ==============================
  kronos_execute u_execute (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .decode       (decode       ),
    .decode_vld   (decode_vld   ),
    .decode_rdy   (decode_rdy   ),
    .regwr_en     (regwr_en     ),
    .regwr_sel    (regwr_sel    ),
    .regwr_data   (regwr_data   ),
    .branch       (branch       ),
    .branch_target(branch_target),
    .data_addr    (data_addr    ),
    .data_wr_data (data_wr_data ),
    .data_mask    (data_mask    ),
    .data_wr_en   (data_wr_en   ),
    .data_req     (data_req     ),
    .data_ack     (data_ack     ),
    .data_rd_data (data_rd_data )
  );

endmodule

//--- testbench/kronos_core_asserts.sv
// ==============================
// Kronos lite bus checks
// req/ack rules on both ports
// ==============================

`timescale 1ns/1ps

module kronos_core_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] instr_addr,
  input logic        instr_req,
  input logic        instr_ack,
  input logic [31:0] data_addr,
  input logic [31:0] data_wr_data,
  input logic        data_wr_en,
  input logic        data_req,
  input logic        data_ack
);

  // ==============================
  // Instruction port
  // ==============================
  a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req && !instr_ack |=> instr_req && $stable(instr_addr))
    else $error("instr_req dropped or instr_addr moved before ack");

  a_instr_ack: assert property (@(posedge clk) disable iff (!rst_n)
    instr_ack |-> instr_req)
    else $error("instr_ack without instr_req");

  // ==============================
  // Data port
  // ==============================
  a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && !data_ack |=> data_req && $stable(data_addr) &&
      $stable(data_wr_data) && $stable(data_wr_en))
    else $error("data request changed before ack");

  a_data_ack: assert property (@(posedge clk) disable iff (!rst_n)
    data_ack |-> data_req)
    else $error("data_ack without data_req");

  // First cycle out of reset is quiet
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !instr_req && !data_req)
    else $error("request raised in the first cycle after reset");

endmodule

bind kronos_core kronos_core_asserts i_kronos_core_asserts (.*);

//--- testbench/kronos_core_tb.sv
// ==============================
// Kronos lite core testbench
// Program table, memory models, store checks
// ==============================

`timescale 1ns/1ps

module kronos_core_tb;

  localparam int NTESTS      = 5;
  localparam int RST_CYCLES  = 3;
  localparam int STALL_LIMIT = 150;
  localparam int DRAIN       = 24;
  // Run budget of 16 instructions at 12 cycles per row plus reset
  localparam int LIMIT       = NTESTS * (16 * 12 + RST_CYCLES);

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic        instr_req;
  logic        instr_ack;
  logic [31:0] instr_data;
  logic [31:0] data_addr;
  logic [31:0] data_wr_data;
  logic [3:0]  data_mask;
  logic        data_wr_en;
  logic        data_req;
  logic        data_ack;
  logic [31:0] data_rd_data;

  // Program table
  string       names [NTESTS];
  logic [31:0] prog [NTESTS][16];
  int          n_stores [NTESTS];
  store_t      exp_st [NTESTS][4];

  logic [31:0] imem [16];
  logic [31:0] dmem [logic [31:0]];
  store_t      captured [$];

  int mismatch_errs;
  int other_errs;
  int cycles;
  int cur_test;
  int i_wait;
  int d_wait;
  logic i_pend;
  logic d_pend;

  kronos_core i_kronos_core (
    .clk         (clk         ),
    .rst_n       (rst_n       ),
    .instr_addr  (instr_addr  ),
    .instr_req   (instr_req   ),
    .instr_ack   (instr_ack   ),
    .instr_data  (instr_data  ),
    .data_addr   (data_addr   ),
    .data_wr_data(data_wr_data),
    .data_mask   (data_mask   ),
    .data_wr_en  (data_wr_en  ),
    .data_req    (data_req    ),
    .data_ack    (data_ack    ),
    .data_rd_data(data_rd_data)
  );

  always #2 clk = ~clk;

  // ==============================
  // Memory models
  // ==============================
  // Instruction memory with zero words past the program
  always @(posedge clk) begin
    if (!rst_n || instr_ack) begin
      instr_ack <= 1'b0;
      i_pend    <= 1'b0;
    end else if (instr_req) begin
      if (!i_pend) begin
        i_pend <= 1'b1;
        i_wait <= $urandom % 4;
      end else if (i_wait == 0) begin
        instr_ack  <= 1'b1;
        instr_data <= (instr_addr < 32'd64) ? imem[instr_addr[5:2]] : 32'd0;
      end else begin
        i_wait <= i_wait - 1;
      end
    end
  end

  // Data memory with an address pattern in unwritten words
  always @(posedge clk) begin
    if (!rst_n || data_ack) begin
      data_ack <= 1'b0;
      d_pend   <= 1'b0;
    end else if (data_req) begin
      if (!d_pend) begin
        d_pend <= 1'b1;
        d_wait <= $urandom % 4;
      end else if (d_wait == 0) begin
        data_ack <= 1'b1;
        // Word accesses only
        check_mask(names[cur_test], 4'hf, data_mask);
        if (data_wr_en) begin
          dmem[data_addr] = data_wr_data;
          captured.push_back({data_addr, data_wr_data});
        end else if (dmem.exists(data_addr)) begin
          data_rd_data <= dmem[data_addr];
        end else begin
          data_rd_data <= data_addr ^ 32'hdead_beef;
        end
      end else begin
        d_wait <= d_wait - 1;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ==============================
  // Instruction encoders
  // ==============================
  function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(int opc, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic expect_store(int t, int k, logic [31:0] addr, logic [31:0] data);
    exp_st[t][k] = {addr, data};
  endtask

  // ==============================
  // Program table
  // ==============================
  task automatic build_table();
    for (int t = 0; t < NTESTS; t++) begin
      for (int i = 0; i < 16; i++) begin
        prog[t][i] = 32'd0;
      end
    end

    // ALU ops folded into four stores
    names[0]    = "alu_ops";
    prog[0][0]  = i_type('h13, 0, 1, 0, 'h5a5);
    prog[0][1]  = i_type('h13, 0, 2, 0, -3);
    prog[0][2]  = r_type(0, 0, 3, 1, 2);
    prog[0][3]  = r_type('h20, 0, 4, 1, 2);
    prog[0][4]  = r_type(0, 7, 5, 3, 4);
    prog[0][5]  = r_type(0, 6, 6, 3, 4);
    prog[0][6]  = r_type(0, 4, 7, 5, 6);
    prog[0][7]  = r_type(0, 2, 8, 2, 1);
    prog[0][8]  = i_type('h13, 7, 9, 1, 'h0f0);
    prog[0][9]  = i_type('h13, 6, 10, 9, 3);
    prog[0][10] = i_type('h13, 4, 11, 10, -1);
    prog[0][11] = r_type(0, 0, 12, 7, 8);
    prog[0][12] = s_type(4, 0, 'h100);
    prog[0][13] = s_type(6, 0, 'h104);
    prog[0][14] = s_type(12, 0, 'h108);
    prog[0][15] = s_type(11, 0, 'h10c);
    n_stores[0] = 4;
    expect_store(0, 0, 32'h100, 32'h0000_05a8);
    expect_store(0, 1, 32'h104, 32'h0000_05aa);
    expect_store(0, 2, 32'h108, 32'h0000_000b);
    expect_store(0, 3, 32'h10c, 32'hffff_ff5c);

    // LUI with back to back consumers
    names[1]    = "lui_hazard";
    prog[1][0]  = u_type(1, 'h12345);
    prog[1][1]  = i_type('h13, 0, 2, 1, 'h678);
    prog[1][2]  = r_type(0, 4, 3, 2, 1);
    prog[1][3]  = s_type(2, 0, 'h200);
    prog[1][4]  = s_type(3, 0, 'h204);
    prog[1][5]  = u_type(4, 'h80000);
    prog[1][6]  = r_type(0, 2, 5, 4, 0);
    prog[1][7]  = s_type(5, 0, 'h208);
    n_stores[1] = 3;
    expect_store(1, 0, 32'h200, 32'h1234_5678);
    expect_store(1, 1, 32'h204, 32'h0000_0678);
    expect_store(1, 2, 32'h208, 32'h0000_0001);

    // Store, load back, add, store again
    names[2]    = "load_store";
    prog[2][0]  = i_type('h13, 0, 1, 0, 'h123);
    prog[2][1]  = i_type('h13, 0, 4, 0, 7);
    prog[2][2]  = s_type(1, 0, 'h300);
    prog[2][3]  = i_type('h03, 2, 2, 0, 'h300);
    prog[2][4]  = r_type(0, 0, 3, 2, 4);
    prog[2][5]  = s_type(3, 0, 'h304);
    n_stores[2] = 2;
    expect_store(2, 0, 32'h300, 32'h0000_0123);
    expect_store(2, 1, 32'h304, 32'h0000_012a);

    // Branches and JAL over stores that must not appear
    names[3]    = "branch_jal";
    prog[3][0]  = i_type('h13, 0, 1, 0, 5);
    prog[3][1]  = i_type('h13, 0, 2, 0, 5);
    prog[3][2]  = b_type(0, 1, 2, 8);
    prog[3][3]  = s_type(1, 0, 'h400);
    prog[3][4]  = b_type(1, 1, 2, 8);
    prog[3][5]  = s_type(2, 0, 'h404);
    prog[3][6]  = b_type(0, 1, 0, 8);
    prog[3][7]  = b_type(1, 1, 0, 8);
    prog[3][8]  = s_type(1, 0, 'h408);
    prog[3][9]  = j_type(5, 8);
    prog[3][10] = s_type(1, 0, 'h40c);
    prog[3][11] = s_type(5, 0, 'h410);
    n_stores[3] = 2;
    expect_store(3, 0, 32'h404, 32'h0000_0005);
    // Link of the JAL at word 9
    expect_store(3, 1, 32'h410, 32'h0000_0028);

    // x0 stays zero
    names[4]    = "x0_write";
    prog[4][0]  = i_type('h13, 0, 0, 0, 'h55);
    prog[4][1]  = i_type('h13, 0, 1, 0, 9);
    prog[4][2]  = r_type(0, 0, 0, 1, 1);
    prog[4][3]  = s_type(0, 0, 'h500);
    prog[4][4]  = s_type(1, 0, 'h504);
    n_stores[4] = 2;
    expect_store(4, 0, 32'h500, 32'h0000_0000);
    expect_store(4, 1, 32'h504, 32'h0000_0009);
  endtask

  // ==============================
  // Checks
  // ==============================
  task automatic check_store(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s %s: expected %08h, actual %08h", name, what, exp, act);
    end
  endtask

  task automatic check_mask(string name, logic [3:0] exp, logic [3:0] act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s data_mask: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
      mismatch_errs++;
      $display("mismatch %s store count: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic run_test(int t);
    int waited;
    int n;
    @(posedge clk);
    rst_n <= 1'b0;
    imem = prog[t];
    dmem.delete();
    captured.delete();
    cur_test = t;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    waited = 0;
    while (captured.size() < n_stores[t] && waited < STALL_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (captured.size() < n_stores[t]) begin
      other_errs++;
      $display("%s: program stalled after %0d of %0d stores",
               names[t], captured.size(), n_stores[t]);
    end
    // Room for any stray store
    repeat (DRAIN) @(posedge clk);

    n = captured.size();
    check_count(names[t], n_stores[t], n);
    if (n > n_stores[t]) begin
      n = n_stores[t];
    end
    for (int k = 0; k < n; k++) begin
      check_store(names[t], $sformatf("store %0d address", k), exp_st[t][k].addr,
                  captured[k].addr);
      check_store(names[t], $sformatf("store %0d data", k), exp_st[t][k].data,
                  captured[k].data);
    end
  endtask

  initial begin
    void'($urandom(32'h9f2cfbad));
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_ack     = 1'b0;
    instr_data    = 32'd0;
    data_ack      = 1'b0;
    data_rd_data  = 32'd0;
    i_pend        = 1'b0;
    d_pend        = 1'b0;
    i_wait        = 0;
    d_wait        = 0;
    cycles        = 0;
    cur_test      = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    build_table();

    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end

    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- kronos_lite.f
+incdir+source
source/kronos_types.sv
source/kronos_fetch.sv
source/kronos_regfile.sv
source/kronos_decode.sv
source/kronos_execute.sv
source/kronos_core.sv
testbench/kronos_core_asserts.sv
testbench/kronos_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the kronos_lite simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f kronos_lite.f \
  --top-module kronos_core_tb -Mdir obj_dir -o kronos_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/kronos_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
exit 1
